/* src/sync_pkg.sv */
// Data width, data word type and the state enums of the synchronizing channel
`default_nettype none

package sync_pkg;

  // Word width carried by every lane and the read side
  localparam int DATA_W = 32;

  // One data word
  typedef logic [DATA_W-1:0] data_t;

  // Producer lane state
  // LANE_PENDING holds write_en until write_done is seen
  typedef enum logic {
    LANE_IDLE,
    LANE_PENDING
  } lane_state_t;

  // Consumer state
  // RD_WAIT holds read_en until read_done is seen
  typedef enum logic {
    RD_IDLE,
    RD_WAIT
  } read_state_t;

  // Round-robin winner for simultaneous writes
  typedef enum logic {
    TURN_0,
    TURN_1
  } turn_t;

endpackage

`default_nettype wire

/* src/mreg_write_if.sv */
// Write bundle of both producer lanes toward the M-structure register, with modports
`default_nettype none

interface mreg_write_if;
  import sync_pkg::*;

  // Lane words, held steady while the enable is high
  data_t data_0;
  data_t data_1;
  // Write requests, level until done
  logic  write_en_0;
  logic  write_en_1;
  // One-cycle commit pulses from the register
  logic  write_done_0;
  logic  write_done_1;

  // Producer side
  modport lanes (
    output data_0, data_1, write_en_0, write_en_1,
    input  write_done_0, write_done_1
  );

  // Register side
  modport mreg (
    input  data_0, data_1, write_en_0, write_en_1,
    output write_done_0, write_done_1
  );

endinterface

`default_nettype wire

/* src/write_port.sv */
// Producer lane write port: holding register and pending-request FSM
`default_nettype none

module write_port (
  input  logic            clk,
  input  logic            reset,
  input  logic            push,
  input  sync_pkg::data_t data_in,
  input  logic            write_done,
  output logic            write_en,
  output sync_pkg::data_t write_data,
  output logic            busy
);
  import sync_pkg::*;

  lane_state_t state;
  data_t       hold;
  logic        accept;

  // Push only taken while idle
  // a push during a pending write is dropped
  assign accept = push && (state == LANE_IDLE);

  // Request FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= LANE_IDLE;
    end else begin
      case (state)
        LANE_IDLE: begin
          if (accept) begin
            state <= LANE_PENDING;
          end
        end
        LANE_PENDING: begin
          // Register committed our word one cycle ago
          if (write_done) begin
            state <= LANE_IDLE;
          end
        end
        default: begin
          state <= LANE_IDLE;
        end
      endcase
    end
  end

  // Word stays put for the whole pending phase
  always_ff @(posedge clk) begin
    if (accept) begin
      hold <= data_in;
    end
  end

  // Enable and busy are the same level
  assign write_en   = (state == LANE_PENDING);
  assign busy       = (state == LANE_PENDING);
  assign write_data = hold;

endmodule

`default_nettype wire

/* src/mstruct_reg.sv */
// M-structure register: full flag, round-robin write arbitration, registered done pulses
`default_nettype none

module mstruct_reg (
  input  logic            clk,
  input  logic            reset,
  mreg_write_if.mreg      wr,
  input  logic            read_en,
  output sync_pkg::data_t read_data,
  output logic            read_done
);
  import sync_pkg::*;

  logic  full;
  data_t stored;
  turn_t turn;

  // Decoded actions for this edge
  logic  write_one;
  logic  write_both;
  logic  write_st;
  logic  read_st;
  logic  take_1;

  // Writes only land on an empty register
  assign write_one  = !full && (wr.write_en_0 ^ wr.write_en_1);
  assign write_both = !full && wr.write_en_0 && wr.write_en_1;
  assign write_st   = write_one || write_both;

  // Reads only complete on a full register
  // so a read and a write never share an edge
  assign read_st = full && read_en;

  // Lane 1 wins when it is the only requester,
  // or when both request and the turn names it
  assign take_1 = write_one ? wr.write_en_1 : (turn == TURN_1);

  // Full flag
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (write_st) begin
      full <= 1'b1;
    end else if (read_st) begin
      full <= 1'b0;
    end
  end

  // Round-robin turn
  // Flips only when both lanes collide
  always_ff @(posedge clk) begin
    if (reset) begin
      turn <= TURN_0;
    end else if (write_both) begin
      turn <= (turn == TURN_0) ? TURN_1 : TURN_0;
    end
  end

  // Stored word
  // Undefined again once it has been read out
  always_ff @(posedge clk) begin
    if (write_st) begin
      stored <= take_1 ? wr.data_1 : wr.data_0;
    end else if (read_st) begin
      stored <= 'x;
    end
  end

  // Read data, meaningful only alongside read_done
  always_ff @(posedge clk) begin
    if (read_st) begin
      read_data <= stored;
    end else begin
      read_data <= 'x;
    end
  end

  // Commit pulses, one cycle after the storing edge
  always_ff @(posedge clk) begin
    if (reset) begin
      wr.write_done_0 <= 1'b0;
      wr.write_done_1 <= 1'b0;
    end else begin
      wr.write_done_0 <= write_st && !take_1;
      wr.write_done_1 <= write_st && take_1;
    end
  end

  // Read pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      read_done <= 1'b0;
    end else begin
      read_done <= read_st;
    end
  end

endmodule

`default_nettype wire

/* src/read_port.sv */
// Consumer read port: request FSM, captured read word and one-cycle valid
`default_nettype none

module read_port (
  input  logic            clk,
  input  logic            reset,
  input  logic            pop,
  input  logic            read_done,
  input  sync_pkg::data_t read_data,
  output logic            read_en,
  output logic            read_busy,
  output sync_pkg::data_t data_out,
  output logic            data_valid
);
  import sync_pkg::*;

  read_state_t state;
  logic        got_word;

  // Word arrives while we are still waiting
  assign got_word = (state == RD_WAIT) && read_done;

  // Request FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RD_IDLE;
    end else begin
      case (state)
        RD_IDLE: begin
          if (pop) begin
            state <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (read_done) begin
            state <= RD_IDLE;
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // Valid pulse for the captured word
  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid <= 1'b0;
    end else begin
      data_valid <= got_word;
    end
  end

  // Register data only lives one cycle, keep our own copy
  always_ff @(posedge clk) begin
    if (got_word) begin
      data_out <= read_data;
    end
  end

  assign read_en   = (state == RD_WAIT);
  assign read_busy = (state == RD_WAIT);

endmodule

`default_nettype wire

/* src/sync_channel_top.sv */
// Channel top level: two write ports, the M-structure register and the read port
`default_nettype none

module sync_channel_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            push_0,
  input  logic            push_1,
  input  sync_pkg::data_t data_in_0,
  input  sync_pkg::data_t data_in_1,
  input  logic            pop,
  output logic            busy_0,
  output logic            busy_1,
  output logic            commit_0,
  output logic            commit_1,
  output logic            read_busy,
  output logic            data_valid,
  output sync_pkg::data_t data_out
);
  import sync_pkg::*;

  // Write bundle between the lanes and the register
  mreg_write_if wr_if ();

  // Read side, plain wires
  logic  read_en;
  logic  read_done;
  data_t read_data;

  // Producer lane 0
  write_port lane0 (
    .clk        (clk),
    .reset      (reset),
    .push       (push_0),
    .data_in    (data_in_0),
    .write_done (wr_if.write_done_0),
    .write_en   (wr_if.write_en_0),
    .write_data (wr_if.data_0),
    .busy       (busy_0)
  );

  // Producer lane 1
  write_port lane1 (
    .clk        (clk),
    .reset      (reset),
    .push       (push_1),
    .data_in    (data_in_1),
    .write_done (wr_if.write_done_1),
    .write_en   (wr_if.write_en_1),
    .write_data (wr_if.data_1),
    .busy       (busy_1)
  );

  // Shared one-slot register
  mstruct_reg mreg (
    .clk       (clk),
    .reset     (reset),
    .wr        (wr_if),
    .read_en   (read_en),
    .read_data (read_data),
    .read_done (read_done)
  );

  // Consumer
  read_port reader (
    .clk        (clk),
    .reset      (reset),
    .pop        (pop),
    .read_done  (read_done),
    .read_data  (read_data),
    .read_en    (read_en),
    .read_busy  (read_busy),
    .data_out   (data_out),
    .data_valid (data_valid)
  );

  // Commit pulses brought out so the arbitration order shows at the top
  assign commit_0 = wr_if.write_done_0;
  assign commit_1 = wr_if.write_done_1;

endmodule

`default_nettype wire

/* verification/mstruct_reg_assert.sv */
// Concurrent assertions on the M-structure register and their bind
`default_nettype none

module mstruct_reg_assert (
  input wire logic            clk,
  input wire logic            reset,
  input wire logic            full,
  input wire logic            write_en_0,
  input wire logic            write_en_1,
  input wire logic            write_done_0,
  input wire logic            write_done_1,
  input wire logic            read_done,
  input wire sync_pkg::turn_t turn
);
  timeunit 1ns;
  timeprecision 1ps;
  import sync_pkg::*;

  // Only one lane commits per edge
  a_one_commit: assert property (@(posedge clk) disable iff (reset)
    !(write_done_0 && write_done_1))
    else $error("both write done pulses high");

  // A write and a read never complete together
  a_write_read_apart: assert property (@(posedge clk) disable iff (reset)
    !((write_done_0 || write_done_1) && read_done))
    else $error("write done together with read_done");

  // Reads come out of a full slot
  a_read_from_full: assert property (@(posedge clk) disable iff (reset)
    read_done |-> $past(full))
    else $error("read_done without a full register");

  // Writes land in an empty slot
  a_write_to_empty: assert property (@(posedge clk) disable iff (reset)
    (write_done_0 || write_done_1) |-> !$past(full))
    else $error("write done without an empty register");

  // Turn moves only on a collision into an empty slot
  a_turn_on_collision: assert property (@(posedge clk) disable iff (reset)
    (turn != $past(turn)) |-> $past(write_en_0 && write_en_1 && !full))
    else $error("turn changed without simultaneous writes");

endmodule

bind mstruct_reg mstruct_reg_assert reg_checks (
  .clk          (clk),
  .reset        (reset),
  .full         (full),
  .write_en_0   (wr.write_en_0),
  .write_en_1   (wr.write_en_1),
  .write_done_0 (wr.write_done_0),
  .write_done_1 (wr.write_done_1),
  .read_done    (read_done),
  .turn         (turn)
);

`default_nettype wire

/* verification/sync_channel_tb.sv */
// Channel testbench with clock, reset, watchdog, compare tasks and directed tests
`default_nettype none

module sync_channel_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sync_pkg::*;

  // Test sizes and the watchdog budget derived from them
  localparam int ROUNDS        = 4;
  localparam int RAND_ITERS    = 16;
  localparam int SINGLE_CYCLES = 12;
  localparam int PAIR_CYCLES   = 14;
  localparam int WAIT_LIMIT    = 24;
  localparam int TEST_CYCLES   = 20 + 2 * SINGLE_CYCLES + 30 + ROUNDS * PAIR_CYCLES + 20
                                 + RAND_ITERS * PAIR_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

  logic  clk;
  logic  reset;
  logic  push_0;
  logic  push_1;
  data_t data_in_0;
  data_t data_in_1;
  logic  pop;
  logic  busy_0;
  logic  busy_1;
  logic  commit_0;
  logic  commit_1;
  logic  read_busy;
  logic  data_valid;
  data_t data_out;

  // Stimulus seed and the round-robin model
  int    seed;
  turn_t model_turn;

  sync_channel_top dut (
    .clk        (clk),
    .reset      (reset),
    .push_0     (push_0),
    .push_1     (push_1),
    .data_in_0  (data_in_0),
    .data_in_1  (data_in_1),
    .pop        (pop),
    .busy_0     (busy_0),
    .busy_1     (busy_1),
    .commit_0   (commit_0),
    .commit_1   (commit_1),
    .read_busy  (read_busy),
    .data_valid (data_valid),
    .data_out   (data_out)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Ends a run that is taking too long
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("Watchdog expired before the tests finished");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic data_t next_word();
    next_word = $random(seed);
  endfunction

  // One-cycle push strobe that returns one falling edge after the drive
  task automatic start_push(input logic p0, input logic p1, input data_t d0, input data_t d1);
    @(negedge clk);
    push_0    = p0;
    push_1    = p1;
    data_in_0 = d0;
    data_in_1 = d1;
    @(negedge clk);
    push_0 = 1'b0;
    push_1 = 1'b0;
  endtask

  // One-cycle pop strobe
  task automatic start_pop();
    @(negedge clk);
    pop = 1'b1;
    @(negedge clk);
    pop = 1'b0;
  endtask

  // Waits for a commit pulse, checks its lane and steps past the pulse
  task automatic await_commit(input string name, input logic exp_lane);
    int n;
    n = 0;
    while (!commit_0 && !commit_1) begin
      if (n == WAIT_LIMIT) begin
        abort_run({name, ": no commit pulse arrived"});
      end else begin
        @(negedge clk);
        n++;
      end
    end
    check_bit({name, " commit_0"}, ~exp_lane, commit_0);
    check_bit({name, " commit_1"}, exp_lane, commit_1);
    @(negedge clk);
  endtask

  // Waits for data_valid and checks the word while staying on the valid cycle
  task automatic await_valid(input string name, input data_t exp);
    int n;
    n = 0;
    while (!data_valid) begin
      if (n == WAIT_LIMIT) begin
        abort_run({name, ": data_valid never came"});
      end else begin
        @(negedge clk);
        n++;
      end
    end
    check_data({name, " data_out"}, exp, data_out);
  endtask

  // Lone write into an empty register followed by a drain
  // The idle lane sees a different word on its input
  task automatic run_single(input string name, input logic lane, input data_t w);
    start_push(~lane, lane, lane ? ~w : w, lane ? w : ~w);
    await_commit(name, lane);
    start_pop();
    await_valid(name, w);
  endtask

  // Colliding writes with the winner taken from the model turn
  task automatic run_pair(input string name, input data_t w0, input data_t w1);
    logic win;
    win = (model_turn == TURN_1);
    model_turn = (model_turn == TURN_0) ? TURN_1 : TURN_0;
    start_push(1'b1, 1'b1, w0, w1);
    await_commit({name, " winner"}, win);
    start_pop();
    await_valid({name, " winner"}, win ? w1 : w0);
    // Loser lands in the same cycle the winner's word is presented
    await_commit({name, " loser"}, ~win);
    start_pop();
    await_valid({name, " loser"}, win ? w0 : w1);
  endtask

  task automatic test_after_reset();
    @(negedge clk);
    check_bit("after_reset busy_0", 1'b0, busy_0);
    check_bit("after_reset busy_1", 1'b0, busy_1);
    check_bit("after_reset read_busy", 1'b0, read_busy);
    check_bit("after_reset data_valid", 1'b0, data_valid);
    check_bit("after_reset commit_0", 1'b0, commit_0);
    check_bit("after_reset commit_1", 1'b0, commit_1);
  endtask

  // Push to commit takes 2 cycles and pop to valid takes 3
  task automatic test_single_exact(input logic lane);
    data_t w;
    string name;
    w    = next_word();
    name = lane ? "single_lane1" : "single_lane0";
    start_push(~lane, lane, lane ? ~w : w, lane ? w : ~w);
    check_bit({name, " commit early"}, 1'b0, commit_0 | commit_1);
    @(negedge clk);
    check_bit({name, " commit_0"}, ~lane, commit_0);
    check_bit({name, " commit_1"}, lane, commit_1);
    check_bit({name, " busy at commit"}, 1'b1, lane ? busy_1 : busy_0);
    @(negedge clk);
    check_bit({name, " busy after commit"}, 1'b0, lane ? busy_1 : busy_0);
    check_bit({name, " commit cleared"}, 1'b0, commit_0 | commit_1);
    start_pop();
    check_bit({name, " read_busy"}, 1'b1, read_busy);
    check_bit({name, " valid cycle 1"}, 1'b0, data_valid);
    @(negedge clk);
    check_bit({name, " valid cycle 2"}, 1'b0, data_valid);
    @(negedge clk);
    check_bit({name, " valid cycle 3"}, 1'b1, data_valid);
    check_data({name, " data_out"}, w, data_out);
    @(negedge clk);
    check_bit({name, " valid cleared"}, 1'b0, data_valid);
    check_bit({name, " read_busy cleared"}, 1'b0, read_busy);
  endtask

  // Lane 1 stalls behind lane 0's word until a pop frees the slot
  task automatic test_blocked_writer();
    data_t w0;
    data_t w1;
    w0 = next_word();
    w1 = next_word();
    start_push(1'b1, 1'b0, w0, w1);
    await_commit("blocked first", 1'b0);
    start_push(1'b0, 1'b1, w0, w1);
    repeat (6) begin
      check_bit("blocked busy_1", 1'b1, busy_1);
      check_bit("blocked commit_1", 1'b0, commit_1);
      @(negedge clk);
    end
    start_pop();
    await_valid("blocked first", w0);
    await_commit("blocked second", 1'b1);
    start_pop();
    await_valid("blocked second", w1);
    check_bit("blocked busy_1 cleared", 1'b0, busy_1);
  endtask

  task automatic test_simultaneous();
    repeat (ROUNDS) begin
      run_pair("simultaneous", next_word(), next_word());
    end
  endtask

  // Reader parks on an empty register
  task automatic test_read_before_write();
    data_t w;
    w = next_word();
    start_pop();
    repeat (6) begin
      check_bit("read_first read_busy", 1'b1, read_busy);
      check_bit("read_first data_valid", 1'b0, data_valid);
      @(negedge clk);
    end
    start_push(1'b1, 1'b0, w, ~w);
    await_commit("read_first", 1'b0);
    await_valid("read_first", w);
  endtask

  task automatic test_random_mix();
    int kind;
    repeat (RAND_ITERS) begin
      kind = $random(seed) & 3;
      if (kind == 0) begin
        run_single("random lane0", 1'b0, next_word());
      end else if (kind == 1) begin
        run_single("random lane1", 1'b1, next_word());
      end else begin
        run_pair("random pair", next_word(), next_word());
      end
    end
  endtask

  // Main sequence
  initial begin
    reset      = 1'b1;
    push_0     = 1'b0;
    push_1     = 1'b0;
    pop        = 1'b0;
    data_in_0  = '0;
    data_in_1  = '0;
    seed       = 118;
    model_turn = TURN_0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_after_reset();
    test_single_exact(1'b0);
    test_single_exact(1'b1);
    test_blocked_writer();
    test_simultaneous();
    test_read_before_write();
    test_random_mix();
    repeat (4) @(negedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
src/sync_pkg.sv
src/mreg_write_if.sv
src/write_port.sv
src/mstruct_reg.sv
src/read_port.sv
src/sync_channel_top.sv
verification/mstruct_reg_assert.sv
verification/sync_channel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the channel testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f tb.f \
  --top-module sync_channel_tb \
  --Mdir obj_dir \
  -o sim_tb

# The simulator status is masked by tee, the log decides
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
